//--- sim/tb_mm_top.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module tb_mm_top import mm_pkg::*;;
    localparam int N = `MM_SIZE;
    localparam int DRIVE_DELAY = 2;
    localparam int DONE_LIMIT = 4 * `MM_RUN_CYCLES + 10;

    logic       clk;
    logic       reset;
    logic       start;
    mm_matrix_t matrix_a;
    mm_matrix_t matrix_b;
    logic       done;
    mm_result_t result;

    integer     seed;
    int         check_count;
    int         error_count;
    int         timeout_count;
    mm_result_t expected;
    mm_matrix_t mat_a;
    mm_matrix_t mat_b;
    event       compare_ev;

    mm_top mm_top_inst (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .matrix_a (matrix_a),
        .matrix_b (matrix_b),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // C = A x B at full accumulator width, row-major
    function automatic mm_result_t ref_multiply(input mm_matrix_t a, input mm_matrix_t b);
        mm_result_t c;
        mm_acc_t    sum;
        c = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = '0;
                for (int k = 0; k < N; k++) begin
                    sum = sum + mm_acc_t'(a[i*N + k]) * mm_acc_t'(b[k*N + j]);
                end
                c[i*N + j] = sum;
            end
        end
        return c;
    endfunction

    function automatic mm_matrix_t identity_matrix();
        mm_matrix_t m;
        m = '0;
        for (int i = 0; i < N; i++) begin
            m[i*N + i] = mm_data_t'(1);
        end
        return m;
    endfunction

    task automatic random_matrix(output mm_matrix_t m);
        for (int k = 0; k < N * N; k++) begin
            m[k] = mm_data_t'($random(seed));
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // Polls done on falling edges until it reaches the wanted level
    task automatic wait_done(input logic level, input int limit);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (done === level) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout: done did not go %s within %0d cycles at %0t ns",
                     level ? "high" : "low", limit, $time);
        end
    endtask

    // Every result element against the reference
    always @(compare_ev) begin
        for (int k = 0; k < N * N; k++) begin
            check_value($sformatf("result[%0d]", k), 64'(result[k]), 64'(expected[k]));
        end
    end

    // One start/done transaction, optionally holding start after done
    task automatic run_product(input mm_matrix_t a, input mm_matrix_t b,
                               input int hold_cycles);
        mm_result_t snapshot;
        matrix_a = a;
        matrix_b = b;
        start = 1'b1;
        wait_done(1'b1, DONE_LIMIT);
        expected = ref_multiply(a, b);
        -> compare_ev;
        snapshot = result;
        for (int h = 0; h < hold_cycles; h++) begin
            @(negedge clk);
            check_value("done while start held", 64'(done), 64'd1);
            for (int k = 0; k < N * N; k++) begin
                check_value($sformatf("held result[%0d]", k), 64'(result[k]),
                            64'(snapshot[k]));
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        wait_done(1'b0, 2);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        seed = 53;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        reset = 1'b1;
        start = 1'b0;
        matrix_a = '0;
        matrix_b = '0;
        expected = '0;

        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Idle state after reset
        @(negedge clk);
        check_value("done after reset", 64'(done), 64'd0);
        expected = '0;
        -> compare_ev;
        @(posedge clk);
        #DRIVE_DELAY;

        // Identity on either side
        random_matrix(mat_b);
        run_product(identity_matrix(), mat_b, 0);
        random_matrix(mat_a);
        run_product(mat_a, identity_matrix(), 0);

        // Random operands, back to back
        repeat (8) begin
            random_matrix(mat_a);
            random_matrix(mat_b);
            run_product(mat_a, mat_b, 0);
        end

        // Largest sums, then a small product to show the clear
        mat_a = '1;
        mat_b = '1;
        run_product(mat_a, mat_b, 0);
        run_product(identity_matrix(), identity_matrix(), 0);

        // Hold start after done, then restart
        random_matrix(mat_a);
        random_matrix(mat_b);
        run_product(mat_a, mat_b, 10);
        random_matrix(mat_a);
        random_matrix(mat_b);
        run_product(mat_a, mat_b, 0);

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src/mm_cfg.svh
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Matrix dimension N
`define MM_SIZE 4

// Operand element width
`define MM_DATA_W 8

// Full product width plus growth for N partial sums
`define MM_ACC_W (2 * `MM_DATA_W + $clog2(`MM_SIZE))

// Wavefronts that carry data, and total cycles until the far corner settles
`define MM_STEPS (2 * `MM_SIZE - 1)
`define MM_RUN_CYCLES (3 * `MM_SIZE - 1)

`endif

//--- src/mm_ctrl.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module mm_ctrl import mm_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     done,
    output logic     clear,
    output logic     feed_en,
    output mm_step_t step
);
    localparam mm_step_t LAST_FEED = mm_step_t'(`MM_STEPS - 1);
    localparam mm_step_t LAST_STEP = mm_step_t'(`MM_RUN_CYCLES - 1);

    mm_state_t state;
    mm_state_t state_next;
    logic      step_advance;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            MM_IDLE: begin
                if (start) begin
                    state_next = MM_FEED;
                end
            end
            MM_FEED: begin
                // First feed cycle is the clear cycle, step holds at 0
                if (!clear && step == LAST_FEED) begin
                    state_next = MM_DRAIN;
                end
            end
            MM_DRAIN: begin
                if (step == LAST_STEP) begin
                    state_next = MM_DONE;
                end
            end
            MM_DONE: begin
                if (!start) begin
                    state_next = MM_IDLE;
                end
            end
            default: begin
                state_next = MM_IDLE;
            end
        endcase
    end

    assign step_advance = (state == MM_FEED && !clear) ||
                          (state == MM_DRAIN && state_next == MM_DRAIN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= MM_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Wavefront counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= '0;
        end else if (state == MM_IDLE) begin
            step <= '0;
        end else if (step_advance) begin
            step <= step + 1'b1;
        end
    end

    // Registered control outputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clear   <= 1'b0;
            feed_en <= 1'b0;
            done    <= 1'b0;
        end else begin
            clear   <= (state == MM_IDLE) && start;
            feed_en <= (state == MM_FEED) && (state_next == MM_FEED);
            // Held while the host keeps start high
            done    <= (state == MM_DONE) && start;
        end
    end

endmodule

//--- src/mm_pkg.sv
`include "mm_cfg.svh"

package mm_pkg;

    typedef logic [`MM_DATA_W-1:0] mm_data_t;
    typedef logic [`MM_ACC_W-1:0] mm_acc_t;

    // Row-major, element (i,j) at index i*N+j
    typedef logic [`MM_SIZE*`MM_SIZE-1:0][`MM_DATA_W-1:0] mm_matrix_t;
    typedef logic [`MM_SIZE*`MM_SIZE-1:0][`MM_ACC_W-1:0] mm_result_t;

    // One element per row or per column
    typedef logic [`MM_SIZE-1:0][`MM_DATA_W-1:0] mm_lane_t;

    // Operands entering the array edges on one cycle
    typedef struct packed {
        mm_lane_t a_lanes;
        mm_lane_t b_lanes;
    } mm_edge_t;

    typedef logic [$clog2(`MM_RUN_CYCLES + 1)-1:0] mm_step_t;

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_FEED,
        MM_DRAIN,
        MM_DONE
    } mm_state_t;

endpackage

//--- src/mm_top.sv
`timescale 1ns/1ps

module mm_top import mm_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  mm_matrix_t matrix_a,
    input  mm_matrix_t matrix_b,
    output logic       done,
    output mm_result_t result
);
    logic     clear;
    logic     feed_en;
    mm_step_t step;
    mm_edge_t edge_ops;

    mm_ctrl ctrl_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .done    (done),
        .clear   (clear),
        .feed_en (feed_en),
        .step    (step)
    );

    skew_feeder feeder_inst (
        .clk      (clk),
        .reset    (reset),
        .feed_en  (feed_en),
        .step     (step),
        .matrix_a (matrix_a),
        .matrix_b (matrix_b),
        .edge_ops (edge_ops)
    );

    systolic_array array_inst (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .edge_ops (edge_ops),
        .result   (result)
    );

endmodule

//--- src/pe_cell.sv
`timescale 1ns/1ps

module pe_cell import mm_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clear,
    input  mm_data_t a_in,
    input  mm_data_t b_in,
    output mm_data_t a_out,
    output mm_data_t b_out,
    output mm_acc_t  acc
);
    logic [2*$bits(mm_data_t)-1:0] product;

    assign product = a_in * b_in;

    // Forward operands one hop right and down
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_out <= '0;
            b_out <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    // Zero operands outside a run keep the sum steady
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else begin
            acc <= acc + mm_acc_t'(product);
        end
    end

endmodule

//--- src/skew_feeder.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module skew_feeder import mm_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       feed_en,
    input  mm_step_t   step,
    input  mm_matrix_t matrix_a,
    input  mm_matrix_t matrix_b,
    output mm_edge_t   edge_ops
);
    localparam int N = `MM_SIZE;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    mm_lane_t a_next;
    mm_lane_t b_next;

    generate
        for (genvar l = 0; l < N; l++) begin : g_lane
            mm_step_t         offset;
            logic             hit;
            logic [IDX_W-1:0] idx;

            // Inner index of wavefront t on lane l is t - l
            assign offset = step - mm_step_t'(l);
            assign hit = feed_en &&
                         (step >= mm_step_t'(l)) &&
                         (offset < mm_step_t'(N));
            assign idx = offset[IDX_W-1:0];

            // A[l][t-l] enters row l, B[t-l][l] enters column l
            assign a_next[l] = hit ? matrix_a[l*N + idx] : '0;
            assign b_next[l] = hit ? matrix_b[idx*N + l] : '0;
        end
    endgenerate

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edge_ops <= '0;
        end else begin
            edge_ops.a_lanes <= a_next;
            edge_ops.b_lanes <= b_next;
        end
    end

endmodule

//--- src/systolic_array.sv
`timescale 1ns/1ps
`include "mm_cfg.svh"

module systolic_array import mm_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,
    input  mm_edge_t   edge_ops,
    output mm_result_t result
);
    localparam int N = `MM_SIZE;

    // Horizontal links carry A, vertical links carry B
    mm_data_t a_link [N][N+1];
    mm_data_t b_link [N+1][N];
    mm_acc_t  acc_grid [N][N];

    generate
        for (genvar r = 0; r < N; r++) begin : g_row_in
            assign a_link[r][0] = edge_ops.a_lanes[r];
        end

        for (genvar c = 0; c < N; c++) begin : g_col_in
            assign b_link[0][c] = edge_ops.b_lanes[c];
        end

        for (genvar r = 0; r < N; r++) begin : g_row
            for (genvar c = 0; c < N; c++) begin : g_col
                pe_cell pe_inst (
                    .clk   (clk),
                    .reset (reset),
                    .clear (clear),
                    .a_in  (a_link[r][c]),
                    .b_in  (b_link[r][c]),
                    .a_out (a_link[r][c+1]),
                    .b_out (b_link[r+1][c]),
                    .acc   (acc_grid[r][c])
                );

                // Cell (r,c) holds C[r][c]
                assign result[r*N + c] = acc_grid[r][c];
            end
        end
    endgenerate

endmodule

//--- tb.f
+incdir+src
src/mm_pkg.sv
src/pe_cell.sv
src/systolic_array.sv
src/skew_feeder.sv
src/mm_ctrl.sv
src/mm_top.sv
sim/tb_mm_top.sv
